//--- design/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// instruction word and address width
`define DEC_WORD_W 32

// architectural register index
`define DEC_REG_W 5

// boot address of the core
`define DEC_RESET_VEC 32'hbfc00000

// ALUs sharing the issue rotation
`define DEC_NUM_ALU 4

`endif

//--- design/decode_pkg.sv
`include "decode_defines.svh"

package decode_pkg;

    // one member per supported instruction
    typedef enum logic [5:0] {
        OP_NONE,
        OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU,
        OP_SUB, OP_SUBU,
        OP_SLT, OP_SLTI, OP_SLTU, OP_SLTIU,
        OP_AND, OP_ANDI, OP_OR, OP_ORI,
        OP_XOR, OP_XORI, OP_NOR,
        OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
        OP_LUI,
        OP_BEQ, OP_BNE, OP_BGEZ, OP_BGTZ, OP_BLEZ, OP_BLTZ,
        OP_BGEZAL, OP_BLTZAL,
        OP_J, OP_JAL, OP_JR, OP_JALR,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW
    } op_e;

    // ALU entries must stay at codes 0 to 3
    typedef enum logic [2:0] {
        FU_ALU0, FU_ALU1, FU_ALU2, FU_ALU3, FU_BRU, FU_LSU, FU_NONE
    } fu_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_SA_ZX, IMM_SIGN, IMM_ZERO, IMM_BR_OFF, IMM_JUMP
    } imm_kind_e;

    typedef struct packed {
        logic [`DEC_WORD_W-1:0] pc;
        logic [`DEC_WORD_W-1:0] word;
    } fetch_t;

    typedef struct packed {
        logic                   en;
        logic [`DEC_WORD_W-1:0] target;
    } redirect_t;

    typedef struct packed {
        op_e                   op;
        fu_e                   fu;
        logic [`DEC_REG_W-1:0] reg1;
        logic                  r1_val;
        logic [`DEC_REG_W-1:0] reg2;
        logic                  r2_val;
        logic [`DEC_REG_W-1:0] reg3;
        logic                  rf_we;
        logic [31:0]           imm;
        logic                  sel_src1;
        logic                  sel_src2;
        logic [`DEC_WORD_W-1:0] pc;
    } issue_t;

endpackage

//--- design/fetch_align.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module fetch_align (
    input  logic                   clk,
    input  logic                   resetn,
    input  decode_pkg::redirect_t  br,
    input  logic                   stall,
    input  logic [`DEC_WORD_W-1:0] pc,
    input  logic [`DEC_WORD_W-1:0] inst_rdata,
    output decode_pkg::fetch_t     cur
);

    // address of the word now on inst_rdata
    logic [`DEC_WORD_W-1:0] sram_pc;
    logic [`DEC_WORD_W-1:0] target;
    logic                   matched;
    logic                   hit;
    decode_pkg::fetch_t     incoming;
    decode_pkg::fetch_t     skid;
    logic                   skid_full;

    always_ff @(posedge clk) begin
        if (!resetn || br.en) begin
            sram_pc <= '0;
        end else begin
            sram_pc <= pc;
        end
    end

    // expected target, open until the next redirect
    always_ff @(posedge clk) begin
        if (!resetn) begin
            matched <= 1'b0;
            target  <= `DEC_RESET_VEC;
        end else if (br.en) begin
            matched <= 1'b0;
            target  <= br.target;
        end else if (hit) begin
            matched <= 1'b1;
        end
    end

    assign hit = matched || (sram_pc == target);
    assign incoming = '{pc: sram_pc, word: inst_rdata};

    // word arriving in the first stalled cycle
    always_ff @(posedge clk) begin
        if (stall && !skid_full) begin
            skid <= incoming;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || br.en || !hit) begin
            cur       <= '0;
            skid_full <= 1'b0;
        end else if (!stall) begin
            // drain the held word before taking new data
            cur       <= skid_full ? skid : incoming;
            skid_full <= 1'b0;
        end else begin
            skid_full <= 1'b1;
        end
    end

endmodule

//--- design/inst_classify.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module inst_classify (
    input  logic [`DEC_WORD_W-1:0]  word,
    output decode_pkg::op_e         op,
    output decode_pkg::imm_kind_e   imm_kind,
    output logic                    known
);

    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;
    logic [5:0] func;
    logic       sa_z;
    logic       rs_z;

    assign opcode = word[31:26];
    assign rs     = word[25:21];
    assign rt     = word[20:16];
    assign rd     = word[15:11];
    assign sa     = word[10:6];
    assign func   = word[5:0];
    assign sa_z   = (sa == 5'd0);
    assign rs_z   = (rs == 5'd0);

    always_comb begin
        op = decode_pkg::OP_NONE;
        case (opcode)
            6'h00: begin
                // SPECIAL, reserved fields must read zero
                case (func)
                    6'h00: op = rs_z ? decode_pkg::OP_SLL : decode_pkg::OP_NONE;
                    6'h02: op = rs_z ? decode_pkg::OP_SRL : decode_pkg::OP_NONE;
                    6'h03: op = rs_z ? decode_pkg::OP_SRA : decode_pkg::OP_NONE;
                    6'h04: op = sa_z ? decode_pkg::OP_SLLV : decode_pkg::OP_NONE;
                    6'h06: op = sa_z ? decode_pkg::OP_SRLV : decode_pkg::OP_NONE;
                    6'h07: op = sa_z ? decode_pkg::OP_SRAV : decode_pkg::OP_NONE;
                    6'h08: begin
                        if (sa_z && rt == 5'd0 && rd == 5'd0) begin
                            op = decode_pkg::OP_JR;
                        end
                    end
                    6'h09: begin
                        if (sa_z && rt == 5'd0) begin
                            op = decode_pkg::OP_JALR;
                        end
                    end
                    6'h20: op = sa_z ? decode_pkg::OP_ADD : decode_pkg::OP_NONE;
                    6'h21: op = sa_z ? decode_pkg::OP_ADDU : decode_pkg::OP_NONE;
                    6'h22: op = sa_z ? decode_pkg::OP_SUB : decode_pkg::OP_NONE;
                    6'h23: op = sa_z ? decode_pkg::OP_SUBU : decode_pkg::OP_NONE;
                    6'h24: op = sa_z ? decode_pkg::OP_AND : decode_pkg::OP_NONE;
                    6'h25: op = sa_z ? decode_pkg::OP_OR : decode_pkg::OP_NONE;
                    6'h26: op = sa_z ? decode_pkg::OP_XOR : decode_pkg::OP_NONE;
                    6'h27: op = sa_z ? decode_pkg::OP_NOR : decode_pkg::OP_NONE;
                    6'h2a: op = sa_z ? decode_pkg::OP_SLT : decode_pkg::OP_NONE;
                    6'h2b: op = sa_z ? decode_pkg::OP_SLTU : decode_pkg::OP_NONE;
                    default: op = decode_pkg::OP_NONE;
                endcase
            end
            // REGIMM picks the branch by rt
            6'h01: begin
                case (rt)
                    5'h00: op = decode_pkg::OP_BLTZ;
                    5'h01: op = decode_pkg::OP_BGEZ;
                    5'h10: op = decode_pkg::OP_BLTZAL;
                    5'h11: op = decode_pkg::OP_BGEZAL;
                    default: op = decode_pkg::OP_NONE;
                endcase
            end
            6'h02: op = decode_pkg::OP_J;
            6'h03: op = decode_pkg::OP_JAL;
            6'h04: op = decode_pkg::OP_BEQ;
            6'h05: op = decode_pkg::OP_BNE;
            6'h06: op = (rt == 5'd0) ? decode_pkg::OP_BLEZ : decode_pkg::OP_NONE;
            6'h07: op = (rt == 5'd0) ? decode_pkg::OP_BGTZ : decode_pkg::OP_NONE;
            6'h08: op = decode_pkg::OP_ADDI;
            6'h09: op = decode_pkg::OP_ADDIU;
            6'h0a: op = decode_pkg::OP_SLTI;
            6'h0b: op = decode_pkg::OP_SLTIU;
            6'h0c: op = decode_pkg::OP_ANDI;
            6'h0d: op = decode_pkg::OP_ORI;
            6'h0e: op = decode_pkg::OP_XORI;
            6'h0f: op = decode_pkg::OP_LUI;
            6'h20: op = decode_pkg::OP_LB;
            6'h21: op = decode_pkg::OP_LH;
            6'h23: op = decode_pkg::OP_LW;
            6'h24: op = decode_pkg::OP_LBU;
            6'h25: op = decode_pkg::OP_LHU;
            6'h28: op = decode_pkg::OP_SB;
            6'h29: op = decode_pkg::OP_SH;
            6'h2b: op = decode_pkg::OP_SW;
            default: op = decode_pkg::OP_NONE;
        endcase
    end

    always_comb begin
        case (op)
            decode_pkg::OP_SLL, decode_pkg::OP_SRL, decode_pkg::OP_SRA:
                imm_kind = decode_pkg::IMM_SA_ZX;
            // lui goes through the sign path, the ALU does the shift
            decode_pkg::OP_ADDI, decode_pkg::OP_ADDIU, decode_pkg::OP_SLTI,
            decode_pkg::OP_SLTIU, decode_pkg::OP_LUI,
            decode_pkg::OP_LB, decode_pkg::OP_LBU, decode_pkg::OP_LH,
            decode_pkg::OP_LHU, decode_pkg::OP_LW,
            decode_pkg::OP_SB, decode_pkg::OP_SH, decode_pkg::OP_SW:
                imm_kind = decode_pkg::IMM_SIGN;
            decode_pkg::OP_ANDI, decode_pkg::OP_ORI, decode_pkg::OP_XORI:
                imm_kind = decode_pkg::IMM_ZERO;
            decode_pkg::OP_BEQ, decode_pkg::OP_BNE, decode_pkg::OP_BGEZ,
            decode_pkg::OP_BGTZ, decode_pkg::OP_BLEZ, decode_pkg::OP_BLTZ,
            decode_pkg::OP_BGEZAL, decode_pkg::OP_BLTZAL:
                imm_kind = decode_pkg::IMM_BR_OFF;
            decode_pkg::OP_J, decode_pkg::OP_JAL:
                imm_kind = decode_pkg::IMM_JUMP;
            default:
                imm_kind = decode_pkg::IMM_NONE;
        endcase
    end

    assign known = (op != decode_pkg::OP_NONE);

endmodule

//--- design/operand_select.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module operand_select (
    input  decode_pkg::fetch_t       cur,
    input  decode_pkg::op_e          op,
    input  decode_pkg::imm_kind_e    imm_kind,
    output logic [`DEC_REG_W-1:0]    reg1,
    output logic                     r1_val,
    output logic [`DEC_REG_W-1:0]    reg2,
    output logic                     r2_val,
    output logic [`DEC_REG_W-1:0]    reg3,
    output logic                     rf_we,
    output logic [31:0]              imm,
    output logic                     sel_src1,
    output logic                     sel_src2
);

    logic [`DEC_WORD_W-1:0] w;
    logic [`DEC_REG_W-1:0]  rt;
    logic [`DEC_REG_W-1:0]  rd;

    assign w    = cur.word;
    assign rt   = w[20:16];
    assign rd   = w[15:11];
    assign reg1 = w[25:21];
    assign reg2 = rt;

    // destination and which sources read the register file
    always_comb begin
        reg3   = '0;
        rf_we  = 1'b0;
        r1_val = 1'b1;
        r2_val = 1'b0;
        case (op)
            decode_pkg::OP_ADD, decode_pkg::OP_ADDU, decode_pkg::OP_SUB,
            decode_pkg::OP_SUBU, decode_pkg::OP_SLT, decode_pkg::OP_SLTU,
            decode_pkg::OP_AND, decode_pkg::OP_OR, decode_pkg::OP_XOR,
            decode_pkg::OP_NOR, decode_pkg::OP_SLLV, decode_pkg::OP_SRLV,
            decode_pkg::OP_SRAV: begin
                reg3   = rd;
                rf_we  = 1'b1;
                r2_val = 1'b1;
            end
            decode_pkg::OP_SLL, decode_pkg::OP_SRL, decode_pkg::OP_SRA: begin
                reg3   = rd;
                rf_we  = 1'b1;
                r1_val = 1'b0;
                r2_val = 1'b1;
            end
            decode_pkg::OP_JALR: begin
                reg3  = rd;
                rf_we = 1'b1;
            end
            decode_pkg::OP_ADDI, decode_pkg::OP_ADDIU, decode_pkg::OP_SLTI,
            decode_pkg::OP_SLTIU, decode_pkg::OP_ANDI, decode_pkg::OP_ORI,
            decode_pkg::OP_XORI, decode_pkg::OP_LB, decode_pkg::OP_LBU,
            decode_pkg::OP_LH, decode_pkg::OP_LHU, decode_pkg::OP_LW: begin
                reg3  = rt;
                rf_we = 1'b1;
            end
            decode_pkg::OP_LUI: begin
                reg3   = rt;
                rf_we  = 1'b1;
                r1_val = 1'b0;
            end
            // link register
            decode_pkg::OP_JAL: begin
                reg3   = `DEC_REG_W'd31;
                rf_we  = 1'b1;
                r1_val = 1'b0;
            end
            decode_pkg::OP_BGEZAL, decode_pkg::OP_BLTZAL: begin
                reg3  = `DEC_REG_W'd31;
                rf_we = 1'b1;
            end
            decode_pkg::OP_BEQ, decode_pkg::OP_BNE, decode_pkg::OP_SB,
            decode_pkg::OP_SH, decode_pkg::OP_SW: begin
                r2_val = 1'b1;
            end
            decode_pkg::OP_J, decode_pkg::OP_NONE: begin
                r1_val = 1'b0;
            end
            default: begin
                r1_val = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (imm_kind)
            decode_pkg::IMM_SA_ZX:  imm = {27'b0, w[10:6]};
            decode_pkg::IMM_SIGN:   imm = {{16{w[15]}}, w[15:0]};
            decode_pkg::IMM_ZERO:   imm = {16'b0, w[15:0]};
            decode_pkg::IMM_BR_OFF: imm = {{14{w[15]}}, w[15:0], 2'b00};
            // region bits come from the jump's own pc
            decode_pkg::IMM_JUMP:   imm = {cur.pc[31:28], w[25:0], 2'b00};
            default:                imm = '0;
        endcase
    end

    assign sel_src1 = (imm_kind == decode_pkg::IMM_SA_ZX);
    assign sel_src2 = (imm_kind == decode_pkg::IMM_SIGN) || (imm_kind == decode_pkg::IMM_ZERO);

endmodule

//--- design/fu_dispatch.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module fu_dispatch (
    input  logic              clk,
    input  logic              resetn,
    input  logic              stall,
    input  logic              present,
    input  decode_pkg::op_e   op,
    output decode_pkg::fu_e   fu
);

    localparam int PTR_W = $clog2(`DEC_NUM_ALU);

    logic [PTR_W-1:0] alu_ptr;
    logic             is_alu;

    always_comb begin
        is_alu = 1'b0;
        case (op)
            decode_pkg::OP_BEQ, decode_pkg::OP_BNE, decode_pkg::OP_BGEZ,
            decode_pkg::OP_BGTZ, decode_pkg::OP_BLEZ, decode_pkg::OP_BLTZ,
            decode_pkg::OP_BGEZAL, decode_pkg::OP_BLTZAL, decode_pkg::OP_J,
            decode_pkg::OP_JAL, decode_pkg::OP_JR, decode_pkg::OP_JALR:
                fu = decode_pkg::FU_BRU;
            decode_pkg::OP_LB, decode_pkg::OP_LBU, decode_pkg::OP_LH,
            decode_pkg::OP_LHU, decode_pkg::OP_LW, decode_pkg::OP_SB,
            decode_pkg::OP_SH, decode_pkg::OP_SW:
                fu = decode_pkg::FU_LSU;
            decode_pkg::OP_NONE:
                fu = decode_pkg::FU_NONE;
            default: begin
                is_alu = 1'b1;
                fu     = decode_pkg::fu_e'(3'(alu_ptr));
            end
        endcase
    end

    // step only when an ALU op actually leaves the stage
    always_ff @(posedge clk) begin
        if (!resetn) begin
            alu_ptr <= '0;
        end else if (present && is_alu && !stall) begin
            alu_ptr <= (alu_ptr == PTR_W'(`DEC_NUM_ALU - 1)) ? '0 : alu_ptr + 1'b1;
        end
    end

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   resetn,
    input  decode_pkg::redirect_t  br,
    input  logic                   stall,
    input  logic [`DEC_WORD_W-1:0] pc,
    input  logic [`DEC_WORD_W-1:0] inst_rdata,
    output decode_pkg::issue_t     issue,
    output logic                   inst_valid
);

    decode_pkg::fetch_t      cur;
    decode_pkg::op_e         op;
    decode_pkg::imm_kind_e   imm_kind;
    decode_pkg::fu_e         fu;
    logic                    known;
    logic                    present;
    logic [`DEC_REG_W-1:0]   reg1;
    logic [`DEC_REG_W-1:0]   reg2;
    logic [`DEC_REG_W-1:0]   reg3;
    logic                    r1_val;
    logic                    r2_val;
    logic                    rf_we;
    logic [31:0]             imm;
    logic                    sel_src1;
    logic                    sel_src2;

    // zero pc marks an empty slot
    assign present = (cur.pc != '0);

    fetch_align u_fetch_align (
        .clk(clk), .resetn(resetn), .br(br), .stall(stall),
        .pc(pc), .inst_rdata(inst_rdata), .cur(cur)
    );

    inst_classify u_inst_classify (
        .word(cur.word), .op(op), .imm_kind(imm_kind), .known(known)
    );

    operand_select u_operand_select (
        .cur(cur), .op(op), .imm_kind(imm_kind),
        .reg1(reg1), .r1_val(r1_val), .reg2(reg2), .r2_val(r2_val),
        .reg3(reg3), .rf_we(rf_we), .imm(imm),
        .sel_src1(sel_src1), .sel_src2(sel_src2)
    );

    fu_dispatch u_fu_dispatch (
        .clk(clk), .resetn(resetn), .stall(stall),
        .present(present), .op(op), .fu(fu)
    );

    // an empty slot issues all zero
    always_comb begin
        issue = '0;
        if (present) begin
            issue = '{op: op, fu: fu, reg1: reg1, r1_val: r1_val, reg2: reg2,
                      r2_val: r2_val, reg3: reg3, rf_we: rf_we, imm: imm,
                      sel_src1: sel_src1, sel_src2: sel_src2, pc: cur.pc};
        end
    end

    assign inst_valid = present && known;

endmodule

//--- tests/tb_decode_stage.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module tb_decode_stage;

    localparam int NROWS = 15;
    localparam int MAX_CYCLES = 2000;
    localparam logic [1:0] CLS_ALU = 2'd0;
    localparam logic [1:0] CLS_BRU = 2'd1;
    localparam logic [1:0] CLS_LSU = 2'd2;
    localparam logic [1:0] CLS_NONE = 2'd3;
    localparam logic [31:0] BASE_A = `DEC_RESET_VEC;
    localparam logic [31:0] BASE_B = `DEC_RESET_VEC + 32'h100;
    // valid addiu, so a leak past the target match shows up as a wrong pc
    localparam logic [31:0] FILLER = 32'h24010001;

    typedef struct packed {
        logic [31:0]     word;
        decode_pkg::op_e op;
        logic [1:0]      cls;
        logic [4:0]      reg3;
        logic            we;
        logic [31:0]     imm;
        logic            s1;
        logic            s2;
        logic            v1;
        logic            v2;
        logic            stl;
    } row_t;

    logic                   clk;
    logic                   resetn;
    decode_pkg::redirect_t  br;
    logic                   stall;
    logic [`DEC_WORD_W-1:0] pc;
    logic [`DEC_WORD_W-1:0] inst_rdata;
    decode_pkg::issue_t     issue;
    logic                   inst_valid;

    row_t               rows [NROWS];
    logic [31:0]        exp_pc [$];
    int                 exp_idx [$];
    int                 seed = 32'h94492192;
    int                 alu_cnt = 0;
    int                 stall_cnt = 0;
    int                 idx;
    logic               stall_q = 1'b0;
    logic               check_zero = 1'b0;
    decode_pkg::issue_t prev_issue;
    logic [2:0]         exp_fu;

    decode_stage uut (
        .clk(clk), .resetn(resetn), .br(br), .stall(stall), .pc(pc),
        .inst_rdata(inst_rdata), .issue(issue), .inst_valid(inst_valid)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic expect_empty_issue(input string name);
        decode_pkg::issue_t zero_issue;
        zero_issue = '0;
        assert (issue === zero_issue) else begin
            $display("ERR %0t %s expected %h got %h", $time, name, zero_issue, issue);
            stop_with_failure();
        end
    endtask

    task automatic load_table();
        rows[0]  = '{32'h00221821, decode_pkg::OP_ADDU, CLS_ALU, 5'd3, 1'b1, 32'h0,
                     1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
        rows[1]  = '{32'h2485fffc, decode_pkg::OP_ADDIU, CLS_ALU, 5'd5, 1'b1, 32'hfffffffc,
                     1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
        rows[2]  = '{32'h000638c0, decode_pkg::OP_SLL, CLS_ALU, 5'd7, 1'b1, 32'h3,
                     1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
        rows[3]  = '{32'h10220002, decode_pkg::OP_BEQ, CLS_BRU, 5'd0, 1'b0, 32'h8,
                     1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
        rows[4]  = '{32'h35098001, decode_pkg::OP_ORI, CLS_ALU, 5'd9, 1'b1, 32'h8001,
                     1'b0, 1'b1, 1'b1, 1'b0, 1'b0};
        rows[5]  = '{32'h8faafff0, decode_pkg::OP_LW, CLS_LSU, 5'd10, 1'b1, 32'hfffffff0,
                     1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
        rows[6]  = '{32'h0c000010, decode_pkg::OP_JAL, CLS_BRU, 5'd31, 1'b1, 32'hb0000040,
                     1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
        rows[7]  = '{32'h016c6822, decode_pkg::OP_SUB, CLS_ALU, 5'd13, 1'b1, 32'h0,
                     1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
        rows[8]  = '{32'hac620008, decode_pkg::OP_SW, CLS_LSU, 5'd0, 1'b0, 32'h8,
                     1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
        rows[9]  = '{32'h0491ffff, decode_pkg::OP_BGEZAL, CLS_BRU, 5'd31, 1'b1, 32'hfffffffc,
                     1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
        rows[10] = '{32'h3c0e1234, decode_pkg::OP_LUI, CLS_ALU, 5'd14, 1'b1, 32'h1234,
                     1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
        rows[11] = '{32'hfc000000, decode_pkg::OP_NONE, CLS_NONE, 5'd0, 1'b0, 32'h0,
                     1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
        rows[12] = '{32'h0022782a, decode_pkg::OP_SLT, CLS_ALU, 5'd15, 1'b1, 32'h0,
                     1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
        rows[13] = '{32'h03e00008, decode_pkg::OP_JR, CLS_BRU, 5'd0, 1'b0, 32'h0,
                     1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        rows[14] = '{32'h02328026, decode_pkg::OP_XOR, CLS_ALU, 5'd16, 1'b1, 32'h0,
                     1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
    endtask

    // row index of an address, or -1 outside both program regions
    function automatic int row_of(input logic [31:0] addr);
        if (addr >= BASE_A && addr < BASE_A + 4 * NROWS) begin
            return (addr - BASE_A) >> 2;
        end
        if (addr >= BASE_B && addr < BASE_B + 4 * NROWS) begin
            return (addr - BASE_B) >> 2;
        end
        return -1;
    endfunction

    task automatic push_region(input logic [31:0] base);
        for (int i = 0; i < NROWS; i++) begin
            exp_pc.push_back(base + 4 * i);
            exp_idx.push_back(i);
        end
    endtask

    // instruction SRAM with one cycle of latency
    always @(posedge clk) begin
        inst_rdata <= (row_of(pc) >= 0) ? rows[row_of(pc)].word : FILLER;
    end

    always @(negedge clk) begin
        if (resetn) begin
            if (stall_q) begin
                assert (issue === prev_issue) else begin
                    $display("ERR %0t issue expected %h got %h", $time, prev_issue, issue);
                    stop_with_failure();
                end
            end
            if (check_zero) begin
                expect_empty_issue("issue after redirect");
                check_zero = 1'b0;
            end
            if (issue.pc != '0 && !stall) begin
                assert (exp_pc.size() > 0) else begin
                    $display("a word issued at pc %h when none was expected", issue.pc);
                    stop_with_failure();
                end
                idx = exp_idx.pop_front();
                expect_value("issue.pc", exp_pc.pop_front(), issue.pc);
                case (rows[idx].cls)
                    CLS_ALU: exp_fu = 3'(alu_cnt % `DEC_NUM_ALU);
                    CLS_BRU: exp_fu = decode_pkg::FU_BRU;
                    CLS_LSU: exp_fu = decode_pkg::FU_LSU;
                    default: exp_fu = decode_pkg::FU_NONE;
                endcase
                expect_value("issue.op", 32'(rows[idx].op), 32'(issue.op));
                expect_value("issue.fu", 32'(exp_fu), 32'(issue.fu));
                expect_value("issue.reg1", 32'(rows[idx].word[25:21]), 32'(issue.reg1));
                expect_value("issue.r1_val", 32'(rows[idx].v1), 32'(issue.r1_val));
                expect_value("issue.reg2", 32'(rows[idx].word[20:16]), 32'(issue.reg2));
                expect_value("issue.r2_val", 32'(rows[idx].v2), 32'(issue.r2_val));
                expect_value("issue.reg3", 32'(rows[idx].reg3), 32'(issue.reg3));
                expect_value("issue.rf_we", 32'(rows[idx].we), 32'(issue.rf_we));
                expect_value("issue.imm", rows[idx].imm, issue.imm);
                expect_value("issue.sel_src1", 32'(rows[idx].s1), 32'(issue.sel_src1));
                expect_value("issue.sel_src2", 32'(rows[idx].s2), 32'(issue.sel_src2));
                expect_value("inst_valid", 32'(rows[idx].op != decode_pkg::OP_NONE),
                             32'(inst_valid));
                if (rows[idx].cls == CLS_ALU) begin
                    alu_cnt++;
                end
            end
            prev_issue = issue;
            stall_q    = stall;
        end
    end

    initial begin
        logic        done;
        logic        in_a;
        logic        do_br;
        logic [31:0] next_pc;
        done       = 1'b0;
        in_a       = 1'b1;
        clk        = 1'b0;
        resetn     = 1'b0;
        br         = '0;
        stall      = 1'b0;
        pc         = BASE_A - 32'd16;
        inst_rdata = '0;
        load_table();
        push_region(BASE_A);
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        expect_value("inst_valid after reset", 32'h0, 32'(inst_valid));
        expect_empty_issue("issue after reset");
        for (int c = 0; c < MAX_CYCLES && !done; c++) begin
            @(negedge clk);
            // second to last row is out, so the last one issues with the redirect
            do_br = in_a && !stall && issue.pc == BASE_A + 4 * (NROWS - 2);
            @(posedge clk);
            if (exp_pc.size() == 0 && !in_a) begin
                done = 1'b1;
            end else begin
                if (br.en) begin
                    br <= '0;
                    check_zero = 1'b1;
                end
                next_pc = stall ? pc : pc + 32'd4;
                if (do_br) begin
                    br        <= '{en: 1'b1, target: BASE_B};
                    stall     <= 1'b0;
                    stall_cnt = 0;
                    next_pc   = BASE_B - 32'd8;
                    in_a      = 1'b0;
                    push_region(BASE_B);
                end else if (stall_cnt > 0) begin
                    stall_cnt--;
                    stall <= 1'b1;
                end else if (!stall && row_of(next_pc) >= 0 && rows[row_of(next_pc)].stl) begin
                    stall_cnt = $random(seed) & 3;
                    stall <= 1'b1;
                end else begin
                    stall <= 1'b0;
                end
                pc <= next_pc;
            end
        end
        if (done) begin
            $display("No errors");
            $finish;
        end else begin
            $display("timeout while waiting for the expected words to issue");
            stop_with_failure();
        end
    end

endmodule

//--- tb.f
+incdir+design
design/decode_pkg.sv
design/fetch_align.sv
design/inst_classify.sv
design/operand_select.sv
design/fu_dispatch.sv
design/decode_stage.sv
tests/tb_decode_stage.sv
